//--- verilog.f
+incdir+source
source/sudoku_pkg.sv
source/grid_fifo.sv
source/sweep_counter.sv
source/solve_ctrl.sv
source/candidate_sweep.sv
source/solution_check.sv
source/sudoku.sv
sim/tb_sudoku.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the sudoku testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_sudoku -Mdir obj_dir -o tb_sudoku
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sudoku > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Test passed" "$LOG"; then
	exit 0
fi
exit 1

//--- sim/tb_sudoku.sv
`include "sudoku_defs.svh"

module tb_sudoku;
	timeunit 1ns;
	timeprecision 100ps;
	import sudoku_pkg::*;

	localparam int CLK_PERIOD = 100;
	// results to collect before the run ends
	localparam int RESULTS = 12;
	localparam int WATCHDOG_CYCLES = RESULTS * (`MAX_SWEEPS + 8) + 20;
	// the controller is idle while a result is shown and the input queue has refilled
	localparam int IN_FLIGHT = `FIFO_DEPTH;

	// puzzle table entries
	localparam int EASY = 0;
	localparam int HARD = 1;
	localparam int FULL = 2;
	localparam int DUP = 3;
	localparam int BLANK = 4;
	localparam int KINDS = 5;

	// one cell missing per row, every blank is a naked single
	localparam grid_t EASY_PUZZLE = {
		36'h034678912, 36'h670195348, 36'h198302567,
		36'h859761023, 36'h426853790, 36'h703924856,
		36'h961037284, 36'h287410635, 36'h345286109
	};
	localparam grid_t EASY_ANSWER = {
		36'h534678912, 36'h672195348, 36'h198342567,
		36'h859761423, 36'h426853791, 36'h713924856,
		36'h961537284, 36'h287419635, 36'h345286179
	};
	// needs search, singles alone stall on it
	localparam grid_t HARD_PUZZLE = {
		36'h800000000, 36'h003600000, 36'h070090200,
		36'h050007000, 36'h000045700, 36'h000100030,
		36'h001000068, 36'h008500010, 36'h090000400
	};
	localparam grid_t FULL_GRID = {
		36'h123456789, 36'h456789123, 36'h789123456,
		36'h234567891, 36'h567891234, 36'h891234567,
		36'h345678912, 36'h678912345, 36'h912345678
	};
	// row 0 starts with two 2s
	localparam grid_t DUP_GRID = {
		36'h223456789, 36'h456789123, 36'h789123456,
		36'h234567891, 36'h567891234, 36'h891234567,
		36'h345678912, 36'h678912345, 36'h912345678
	};

	logic  clk;
	logic  rst;
	grid_t puzzle_in;
	grid_t puzzle_out;
	logic  puzzle_oe;
	logic  next_puzzle;
	logic  solution;
	logic  give_up;

	// parent model state
	logic [15:0]      lfsr;
	logic [KINDS-1:0] shown;
	logic [KINDS-1:0] reached;
	int               show_idx;
	int               show_next;
	bit               advance_due;
	int               wait_left;

	// bookkeeping
	int cyc;
	int captures;
	int results;
	int prev_appear;
	bit in_queue_filled;
	int exp_kind[$];
	int exp_edge[$];

	sudoku dut (
		.clk(clk),
		.rst(rst),
		.puzzle_in(puzzle_in),
		.puzzle_out(puzzle_out),
		.puzzle_oe(puzzle_oe),
		.next_puzzle(next_puzzle),
		.solution(solution),
		.give_up(give_up)
	);

	task automatic stop_run();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string test, input logic [323:0] expected,
		input logic [323:0] actual);
		$display("Fail %s expected %0h actual %0h", test, expected, actual);
		stop_run();
	endtask

	task automatic rule_broken(input string what);
		$display("%s", what);
		stop_run();
	endtask

	function automatic grid_t puzzle_of(input int idx);
		case (idx)
			EASY: return EASY_PUZZLE;
			HARD: return HARD_PUZZLE;
			FULL: return FULL_GRID;
			DUP: return DUP_GRID;
			default: return '0;
		endcase
	endfunction

	function automatic string kind_name(input int idx);
		case (idx)
			EASY: return "easy";
			HARD: return "hard";
			FULL: return "full";
			DUP: return "dup";
			default: return "blank";
		endcase
	endfunction

	function automatic cell_t cell_at(input grid_t g, input int r, input int c);
		return g[80 - (r * 9 + c)];
	endfunction

	// every row, column and box must hold each of 1..9 exactly once
	function automatic bit grid_is_solved(input grid_t g);
		int in_row;
		int in_col;
		int in_box;
		for (int u = 0; u < 9; u++)
		begin
			for (int v = 1; v <= 9; v++)
			begin
				in_row = 0;
				in_col = 0;
				in_box = 0;
				for (int k = 0; k < 9; k++)
				begin
					if (cell_at(g, u, k) == cell_t'(v))
						in_row++;
					if (cell_at(g, k, u) == cell_t'(v))
						in_col++;
					if (cell_at(g, (u / 3) * 3 + k / 3, (u % 3) * 3 + k % 3) == cell_t'(v))
						in_box++;
				end
				if (in_row != 1 || in_col != 1 || in_box != 1)
					return 1'b0;
			end
		end
		return 1'b1;
	endfunction

	// fibonacci lfsr, taps 16 14 13 11, one step per bit taken
	function automatic int draw_bits(input int n);
		int   value;
		logic fb;
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			value = (value << 1) | int'(fb);
		end
		return value;
	endfunction

	// random order over the entries not yet shown, then free choice
	function automatic int choose_next();
		int left;
		int pick;
		int idx;
		left = 0;
		idx = 0;
		for (int k = 0; k < KINDS; k++)
		begin
			if (!shown[k])
				left++;
		end
		if (left == 0)
		begin
			idx = draw_bits(3) % KINDS;
		end
		else
		begin
			pick = draw_bits(3) % left;
			for (int k = 0; k < KINDS; k++)
			begin
				if (!shown[k])
				begin
					if (pick == 0)
						idx = k;
					pick--;
				end
			end
		end
		shown[idx] = 1'b1;
		return idx;
	endfunction

	// one result at the output, compared with its capture
	task automatic take_result();
		int    kind;
		int    cap_edge;
		int    limit;
		grid_t given;
		grid_t expected;
		bit    solved;
		bit    want_solution;
		assert (exp_kind.size() > 0)
		else rule_broken("result arrived with no captured puzzle outstanding");
		kind = exp_kind.pop_front();
		cap_edge = exp_edge.pop_front();
		given = puzzle_of(kind);
		solved = grid_is_solved(puzzle_out);
		// givens are never touched by the solver
		for (int i = 0; i < 81; i++)
		begin
			assert (given[i] == '0 || puzzle_out[i] == given[i])
			else value_mismatch("givens", 324'(given[i]), 324'(puzzle_out[i]));
		end
		assert (solution == solved)
		else value_mismatch("checker", 324'(solved), 324'(solution));
		// the hard grid may end anywhere, only its flag is known
		expected = (kind == EASY) ? EASY_ANSWER : given;
		want_solution = (kind == EASY || kind == FULL);
		if (kind != HARD)
		begin
			assert (puzzle_out == expected)
			else value_mismatch({kind_name(kind), "_grid"}, 324'(expected), 324'(puzzle_out));
		end
		assert (solution == want_solution)
		else value_mismatch({kind_name(kind), "_flag"}, 324'(want_solution), 324'(solution));
		// latency window counted from the capture edge
		assert (cyc - cap_edge >= 4)
		else value_mismatch("min_latency", 324'(cap_edge + 4), 324'(cyc));
		limit = ((cap_edge > prev_appear) ? cap_edge : prev_appear) + `MAX_SWEEPS + 4;
		assert (cyc <= limit)
		else value_mismatch("max_latency", 324'(limit), 324'(cyc));
		prev_appear = cyc;
		reached[kind] = 1'b1;
		results++;
	endtask

	task automatic finish_run();
		assert (captures - results == IN_FLIGHT)
		else value_mismatch("in_flight", 324'(IN_FLIGHT), 324'(captures - results));
		assert (in_queue_filled)
		else rule_broken("input queue never filled, back-pressure was not reached");
		if (reached == '1)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			rule_broken("some puzzle kinds never produced a result");
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		lfsr = 16'd78;
		shown = '0;
		reached = '0;
		advance_due = 1'b0;
		wait_left = 0;
		cyc = 0;
		captures = 0;
		results = 0;
		prev_appear = 0;
		in_queue_filled = 1'b0;
		show_next = choose_next();
		show_idx <= show_next;
		puzzle_in <= puzzle_of(show_next);
		rst <= 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
	end

	// parent shows the chosen puzzle from the next rising edge
	always @(posedge clk)
	begin
		show_idx <= show_next;
		puzzle_in <= puzzle_of(show_next);
	end

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		cyc = cyc + 1;
		if (!rst)
		begin
			// neither sending nor asking means the input queue is full
			if (!next_puzzle && !puzzle_oe)
				in_queue_filled = 1'b1;
			if (puzzle_oe)
				take_result();
			if (next_puzzle)
			begin
				// taken by the queue at the coming rising edge
				exp_kind.push_back(show_idx);
				exp_edge.push_back(cyc + 1);
				captures++;
				if (!advance_due)
				begin
					advance_due = 1'b1;
					wait_left = draw_bits(1);
				end
			end
			// idle cycles before the parent moves on
			if (advance_due)
			begin
				if (wait_left == 0)
				begin
					show_next = choose_next();
					advance_due = 1'b0;
				end
				else
				begin
					wait_left--;
				end
			end
			if (results == RESULTS)
				finish_run();
		end
	end

	assert property (@(negedge clk) (rst || $past(rst)) |-> (!puzzle_oe && !solution && !give_up))
	else rule_broken("result strobes active during reset or right after it");

	assert property (@(negedge clk) $fell(rst) |-> next_puzzle)
	else rule_broken("next_puzzle low in the first cycle after reset");

	assert property (@(negedge clk) !(solution && give_up))
	else rule_broken("solution and give_up high together");

	// nothing leaves the engine without puzzle_oe
	assert property (@(negedge clk) !puzzle_oe |-> (!solution && !give_up && puzzle_out == '0))
	else rule_broken("result flags or data shown without puzzle_oe");

	assert property (@(negedge clk) disable iff (rst) puzzle_oe |-> (solution != give_up))
	else rule_broken("puzzle_oe high without exactly one of solution and give_up");

	assert property (@(negedge clk) puzzle_oe |-> !next_puzzle)
	else rule_broken("next_puzzle high while a result is sent");

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		rule_broken("watchdog expired before all results arrived");
	end

endmodule

//--- source/sudoku.sv
`include "sudoku_defs.svh"

module sudoku (
	input  logic              clk,
	input  logic              rst,
	input  sudoku_pkg::grid_t puzzle_in,
	output sudoku_pkg::grid_t puzzle_out,
	output logic              puzzle_oe,
	output logic              next_puzzle,
	output logic              solution,
	output logic              give_up
);
	import sudoku_pkg::*;

	// input queue
	logic  in_empty;
	logic  in_full;
	logic  in_pop;
	grid_t in_head;

	// output queue
	logic  out_empty;
	logic  out_full;
	logic  out_push;
	grid_t out_head;

	// solver
	logic  load;
	logic  sweep_en;
	logic  count_clr;
	logic  count_en;
	logic  spent;
	logic  complete;
	logic  progress;
	logic  head_valid;
	grid_t work_grid;

	// parent shows its next puzzle, captured whenever next_puzzle is high
	grid_fifo #(.DEPTH(`FIFO_DEPTH)) ififo (
		.clk(clk),
		.rst(rst),
		.push(next_puzzle),
		.din(puzzle_in),
		.pop(in_pop),
		.dout(in_head),
		.empty(in_empty),
		.full(in_full)
	);

	solve_ctrl ctrl (
		.clk(clk),
		.rst(rst),
		.in_empty(in_empty),
		.out_full(out_full),
		.complete(complete),
		.progress(progress),
		.spent(spent),
		.in_pop(in_pop),
		.load(load),
		.sweep_en(sweep_en),
		.count_clr(count_clr),
		.count_en(count_en),
		.out_push(out_push)
	);

	sweep_counter cnt (
		.clk(clk),
		.rst(rst),
		.clr(count_clr),
		.en(count_en),
		.spent(spent)
	);

	candidate_sweep sweep (
		.clk(clk),
		.rst(rst),
		.load(load),
		.load_grid(in_head),
		.sweep_en(sweep_en),
		.grid(work_grid),
		.complete(complete),
		.progress(progress)
	);

	// parent takes one result per cycle, so the queue pops on puzzle_oe
	grid_fifo #(.DEPTH(`FIFO_DEPTH)) ofifo (
		.clk(clk),
		.rst(rst),
		.push(out_push),
		.din(work_grid),
		.pop(puzzle_oe),
		.dout(out_head),
		.empty(out_empty),
		.full(out_full)
	);

	// judge the result at the output head as it leaves
	solution_check check (
		.grid(out_head),
		.valid(head_valid)
	);

	assign puzzle_oe = !out_empty;
	// never ask for a puzzle in a cycle that sends a result
	assign next_puzzle = !in_full && !puzzle_oe;
	assign puzzle_out = puzzle_oe ? out_head : '0;
	assign solution = puzzle_oe && head_valid;
	assign give_up = puzzle_oe && !head_valid;

endmodule

//--- source/solution_check.sv
module solution_check (
	input  sudoku_pkg::grid_t grid,
	output logic              valid
);
	import sudoku_pkg::*;

	logic [8:0][8:0] row_seen;
	logic [8:0][8:0] col_seen;
	logic [8:0][8:0] box_seen;
	logic            cells_ok;

	always_comb
	begin
		unit_masks(grid, row_seen, col_seen, box_seen);
	end

	// every cell must hold 1..9, no blanks and no a..f
	always_comb
	begin
		cells_ok = 1'b1;
		for (int i = 0; i < 81; i++)
		begin
			if (value_bit(grid[i]) == '0)
			begin
				cells_ok = 1'b0;
			end
		end
	end

	// nine legal cells covering all nine values means each value once
	always_comb
	begin
		valid = cells_ok;
		for (int u = 0; u < 9; u++)
		begin
			if (row_seen[u] != 9'h1ff || col_seen[u] != 9'h1ff || box_seen[u] != 9'h1ff)
			begin
				valid = 1'b0;
			end
		end
	end

endmodule

//--- source/candidate_sweep.sv
module candidate_sweep (
	input  logic              clk,
	input  logic              rst,
	input  logic              load,
	input  sudoku_pkg::grid_t load_grid,
	input  logic              sweep_en,
	output sudoku_pkg::grid_t grid,
	output logic              complete,
	output logic              progress
);
	import sudoku_pkg::*;

	logic [8:0][8:0] row_mask;
	logic [8:0][8:0] col_mask;
	logic [8:0][8:0] box_mask;
	grid_t           next_grid;
	logic [80:0]     filled;

	// pick the value of a one-hot candidate mask
	function automatic cell_t single_value(input logic [8:0] cand);
		cell_t v;
		v = '0;
		for (int i = 0; i < 9; i++)
		begin
			if (cand[i])
			begin
				v = cell_t'(i + 1);
			end
		end
		return v;
	endfunction

	// values already placed, per unit
	always_comb
	begin
		unit_masks(grid, row_mask, col_mask, box_mask);
	end

	// one naked-single pass over all 81 cells at once
	always_comb
	begin
		logic [8:0] cand;
		int         idx;
		next_grid = grid;
		filled = '0;
		for (int r = 0; r < 9; r++)
		begin
			for (int c = 0; c < 9; c++)
			begin
				idx = 80 - (r * 9 + c);
				// values not yet seen in the row, column or box
				cand = ~(row_mask[r] | col_mask[c] | box_mask[(r / 3) * 3 + c / 3]);
				// only empty cells, givens stay as they are
				if (grid[idx] == '0 && cand != '0 && (cand & (cand - 9'd1)) == '0)
				begin
					next_grid[idx] = single_value(cand);
					filled[idx] = 1'b1;
				end
			end
		end
	end

	always_comb
	begin
		complete = 1'b1;
		for (int i = 0; i < 81; i++)
		begin
			if (grid[i] == '0)
			begin
				complete = 1'b0;
			end
		end
	end

	// working grid, load wins over a pass
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			grid <= load_grid;
		end
		else if (sweep_en)
		begin
			grid <= next_grid;
		end
	end

	// set on load so a fresh puzzle always gets a first pass
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			progress <= 1'b0;
		end
		else if (load)
		begin
			progress <= 1'b1;
		end
		else if (sweep_en)
		begin
			progress <= |filled;
		end
	end

endmodule

//--- source/solve_ctrl.sv
module solve_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic in_empty,
	input  logic out_full,
	input  logic complete,
	input  logic progress,
	input  logic spent,
	output logic in_pop,
	output logic load,
	output logic sweep_en,
	output logic count_clr,
	output logic count_en,
	output logic out_push
);
	import sudoku_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic        stop;

	// any of these ends the sweeping for this puzzle
	// progress reads 1 right after load so the first pass always runs
	assign stop = complete || !progress || spent;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	always_comb
	begin
		state_next = state;
		case (state)
			IDLE:
			begin
				if (!in_empty)
				begin
					state_next = LOAD;
				end
			end
			// single cycle, pop and load happen on its closing edge
			LOAD:
				state_next = SWEEP;
			SWEEP:
			begin
				if (stop)
				begin
					state_next = WRITE;
				end
			end
			// hold the grid until the output queue has room
			WRITE:
			begin
				if (!out_full)
				begin
					state_next = IDLE;
				end
			end
			default:
				state_next = IDLE;
		endcase
	end

	// load the head into the sweep register as it leaves the queue
	assign in_pop = (state == LOAD);
	assign load = (state == LOAD);
	assign count_clr = (state == LOAD);

	// no pass on the cycle that decides to stop
	assign sweep_en = (state == SWEEP) && !stop;
	assign count_en = sweep_en;

	assign out_push = (state == WRITE) && !out_full;

endmodule

//--- source/sweep_counter.sv
`include "sudoku_defs.svh"

module sweep_counter (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic en,
	output logic spent
);

	localparam int CNT_W = $clog2(`MAX_SWEEPS + 1);

	logic [CNT_W-1:0] count;

	// passes since the last clear, held at the budget
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (clr)
		begin
			count <= '0;
		end
		else if (en && !spent)
		begin
			count <= count + 1'b1;
		end
	end

	// budget gone, controller must write back whatever it has
	assign spent = (count == CNT_W'(`MAX_SWEEPS));

endmodule

//--- source/grid_fifo.sv
module grid_fifo #(
	parameter int DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               push,
	input  sudoku_pkg::grid_t  din,
	input  logic               pop,
	output sudoku_pkg::grid_t  dout,
	output logic               empty,
	output logic               full
);
	import sudoku_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	grid_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	// push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// storage only, no reset needed on the entries
	always_ff @(posedge clk)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// pointers wrap explicitly so DEPTH need not be a power of two
			if (do_push)
			begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy, unchanged on simultaneous push and pop
			if (do_push && !do_pop)
			begin
				count <= count + 1'b1;
			end
			else if (do_pop && !do_push)
			begin
				count <= count - 1'b1;
			end
		end
	end

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	// head entry, meaningless while empty
	assign dout = mem[rd_ptr];

endmodule

//--- source/sudoku_pkg.sv
package sudoku_pkg;

	// one cell, 0 = empty, 1..9 = value, a..f never used
	typedef logic [3:0] cell_t;

	// 81 cells row-major, row 0 col 0 at the msb end
	// cell (r,c) lives at index 80 - (r*9 + c)
	typedef cell_t [80:0] grid_t;

	// solver controller states
	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		SWEEP,
		WRITE
	} ctrl_state_t;

	// one-hot of a cell value, bit v-1 for value v, empty or illegal gives 0
	function automatic logic [8:0] value_bit(input cell_t v);
		logic [8:0] m;
		m = '0;
		if (v >= 4'd1 && v <= 4'd9)
		begin
			m[v - 4'd1] = 1'b1;
		end
		return m;
	endfunction

	// values present in each row, column and 3x3 box of a grid
	function automatic void unit_masks(
		input grid_t g,
		output logic [8:0][8:0] rows,
		output logic [8:0][8:0] cols,
		output logic [8:0][8:0] boxes
	);
		logic [8:0] m;
		rows = '0;
		cols = '0;
		boxes = '0;
		for (int r = 0; r < 9; r++)
		begin
			for (int c = 0; c < 9; c++)
			begin
				m = value_bit(g[80 - (r * 9 + c)]);
				rows[r] = rows[r] | m;
				cols[c] = cols[c] | m;
				boxes[(r / 3) * 3 + c / 3] = boxes[(r / 3) * 3 + c / 3] | m;
			end
		end
	endfunction

endpackage

//--- source/sudoku_defs.svh
`ifndef SUDOKU_DEFS_SVH
`define SUDOKU_DEFS_SVH

// entries in each grid queue
`define FIFO_DEPTH 4

// propagation passes allowed per puzzle before giving up
`define MAX_SWEEPS 40

`endif
